// File: source/memConfig.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Word and address widths
`define MEM_WORD_WIDTH 64
`define MEM_ADDR_WIDTH 64

// Instruction segment starts at word 0
`define MEM_INSTR_WORDS 32

// Data segment is a row of equal banks
`define MEM_BANK_WORDS 64
`define MEM_BANK_COUNT 4

// Data follows straight after the instruction words
`define MEM_DATA_BASE `MEM_INSTR_WORDS

// Everything from the end of the last bank upward is unmapped

`endif

// File: source/memPkg.sv
`default_nettype none

package memPkg;

`include "memConfig.svh"

    // Offset has to index both the ROM and a single bank
    localparam int instrIdxWidth = $clog2(`MEM_INSTR_WORDS);
    localparam int bankIdxWidth  = $clog2(`MEM_BANK_WORDS);
    localparam int offsetWidth   = (instrIdxWidth > bankIdxWidth) ? instrIdxWidth
                                                                  : bankIdxWidth;

    typedef logic [`MEM_WORD_WIDTH-1:0] wordT;
    typedef logic [`MEM_ADDR_WIDTH-1:0] addrT;

    typedef enum logic [1:0] {
        regionInstr,                      // Read-only program words
        regionData,                       // Banked read/write storage
        regionNone                        // Unmapped
    } regionT;

    typedef logic [$clog2(`MEM_BANK_COUNT)-1:0] bankIdxT;
    typedef logic [offsetWidth-1:0]              offsetT;

endpackage

`default_nettype wire

// File: source/memReqIf.sv
`timescale 1ns/10ps
`default_nettype none

interface memReqIf import memPkg::*; ();

    logic    valid;                       // One pulse per request
    logic    read;
    logic    write;
    regionT  region;
    bankIdxT bank;
    offsetT  offset;                      // Word inside bank or ROM
    wordT    wdata;

    modport decoder (
        output valid,
        output read,
        output write,
        output region,
        output bank,
        output offset,
        output wdata
    );

    modport storage (
        input valid,
        input read,
        input write,
        input region,
        input bank,
        input offset,
        input wdata
    );

endinterface

`default_nettype wire

// File: source/segmentDecoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "memConfig.svh"

module segmentDecoder import memPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     read,
    input  logic     write,
    input  addrT     address,
    input  wordT     wdata,
    memReqIf.decoder req
);

    localparam addrT instrEnd = addrT'(`MEM_INSTR_WORDS);
    localparam addrT dataBase = addrT'(`MEM_DATA_BASE);
    localparam addrT dataEnd  = addrT'(`MEM_DATA_BASE + `MEM_BANK_COUNT * `MEM_BANK_WORDS);

    localparam int instrBits    = $clog2(`MEM_INSTR_WORDS);
    localparam int bankWordBits = $clog2(`MEM_BANK_WORDS);
    localparam int bankBits     = $bits(bankIdxT);

    logic    isInstr;
    logic    isData;
    addrT    dataRel;                     // Address relative to first data word
    regionT  regionNext;
    bankIdxT bankNext;
    offsetT  offsetNext;

    // Full-width compares so any upper bit set lands in regionNone
    assign isInstr = (address < instrEnd);
    assign isData  = (address >= dataBase) && (address < dataEnd);
    assign dataRel = address - dataBase;

    always_comb begin
        regionNext = regionNone;
        bankNext   = '0;
        offsetNext = '0;
        if (isInstr) begin
            regionNext = regionInstr;
            offsetNext = offsetT'(address[instrBits-1:0]);
        end else if (isData) begin
            regionNext = regionData;
            bankNext   = bankIdxT'(dataRel[bankWordBits +: bankBits]);   // Upper bits pick bank
            offsetNext = offsetT'(dataRel[bankWordBits-1:0]);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            req.valid  <= 1'b0;
            req.read   <= 1'b0;
            req.write  <= 1'b0;
            req.region <= regionNone;
        end else begin
            req.valid  <= read | write;   // Any strobe is a request
            req.read   <= read;
            req.write  <= write;
            req.region <= regionNext;
        end
    end

    // Payload only moves on a request
    always_ff @(posedge clk) begin
        if (read | write) begin
            req.bank   <= bankNext;
            req.offset <= offsetNext;
            req.wdata  <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: source/bankStorage.sv
`timescale 1ns/10ps
`default_nettype none

`include "memConfig.svh"

module bankStorage import memPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    memReqIf.storage req,
    output logic     rspValid,
    output wordT     rdata
);

    localparam int instrBits    = $clog2(`MEM_INSTR_WORDS);
    localparam int bankWordBits = $clog2(`MEM_BANK_WORDS);
    localparam int progWords    = 13;

    // Fixed program image at the bottom of the instruction segment
    localparam wordT programTable [progWords] = '{
        64'hE04F000F0000000,
        64'hE28000020000000,
        64'hE3A0A0400000000,
        64'hE04F100F0000000,
        64'hE15A00010000000,
        64'hA0000050000000,
        64'hE28120000000000,
        64'hE00230000000000,
        64'hE78130000000000,
        64'hE59140000000000,
        64'hE28110010000000,
        64'hE80000090000000,
        64'hE28110640000000
    };

    wordT instrRom  [`MEM_INSTR_WORDS];
    wordT dataBanks [`MEM_BANK_COUNT][`MEM_BANK_WORDS];

    logic [instrBits-1:0]    romIdx;
    logic [bankWordBits-1:0] bankWordIdx;
    logic                    bankWrite;
    wordT                    readWord;

    // ROM is constant, program words first and zeros above
    for (genvar i = 0; i < `MEM_INSTR_WORDS; i++) begin : genRom
        if (i < progWords) begin : genProg
            assign instrRom[i] = programTable[i];
        end else begin : genZero
            assign instrRom[i] = '0;
        end
    end

    assign romIdx      = req.offset[instrBits-1:0];
    assign bankWordIdx = req.offset[bankWordBits-1:0];

    // Instruction and unmapped writes are dropped here
    assign bankWrite = req.valid && req.write && (req.region == regionData);

    always_comb begin
        case (req.region)
            regionInstr: readWord = instrRom[romIdx];
            regionData:  readWord = dataBanks[req.bank][bankWordIdx];
            default:     readWord = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bankWrite) begin
            dataBanks[req.bank][bankWordIdx] <= req.wdata;
        end
    end

    // Read samples the word before a same-cycle write lands
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rspValid <= 1'b0;
            rdata    <= '0;
        end else begin
            rspValid <= req.valid;    // Every request answers
            if (req.valid && req.read) begin
                rdata <= readWord;
            end else begin
                rdata <= '0;          // Write-only and idle give zero
            end
        end
    end

endmodule

`default_nettype wire

// File: source/segmentedMemory.sv
`timescale 1ns/10ps
`default_nettype none

module segmentedMemory import memPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic read,
    input  logic write,
    input  addrT address,
    input  wordT wdata,
    output logic rspValid,
    output wordT rdata
);

    // Decoded request between the two stages
    memReqIf reqBus ();

    // Stage 1 registers and classifies the address
    segmentDecoder segmentDecoder_inst (
        .clk     (clk),
        .arstN   (arstN),
        .read    (read),
        .write   (write),
        .address (address),
        .wdata   (wdata),
        .req     (reqBus.decoder)
    );

    // Stage 2 does the access and registers the response
    bankStorage bankStorage_inst (
        .clk      (clk),
        .arstN    (arstN),
        .req      (reqBus.storage),
        .rspValid (rspValid),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

// File: tests/segmentedMemoryTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "memConfig.svh"

module segmentedMemoryTb import memPkg::*; ();

    localparam int maxCycles = 2000;      // Tests take a few hundred cycles
    localparam int dataEnd   = `MEM_DATA_BASE + `MEM_BANK_COUNT * `MEM_BANK_WORDS;

    logic clk;
    logic arstN;
    logic read;
    logic write;
    addrT address;
    wordT wdata;
    logic rspValid;
    wordT rdata;

    int          cycleCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    logic [31:0] rngState;

    // Expected responses in request order
    wordT expWord [$];
    addrT expAddr [$];
    int   expDue  [$];

    wordT shadow [addrT];                 // Data words written so far

    segmentedMemory segmentedMemory_inst (
        .clk      (clk),
        .arstN    (arstN),
        .read     (read),
        .write    (write),
        .address  (address),
        .wdata    (wdata),
        .rspValid (rspValid),
        .rdata    (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("timeout: run still busy after %0d cycles", maxCycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    function automatic wordT randomWord();
        wordT w;
        rngState = xorshift(rngState);
        w[63:32] = rngState;
        rngState = xorshift(rngState);
        w[31:0]  = rngState;
        return w;
    endfunction

    // Program words at the bottom of the instruction segment
    function automatic wordT programWord(input int idx);
        case (idx)
            0:       return 64'hE04F000F0000000;
            1:       return 64'hE28000020000000;
            2:       return 64'hE3A0A0400000000;
            3:       return 64'hE04F100F0000000;
            4:       return 64'hE15A00010000000;
            5:       return 64'hA0000050000000;
            6:       return 64'hE28120000000000;
            7:       return 64'hE00230000000000;
            8:       return 64'hE78130000000000;
            9:       return 64'hE59140000000000;
            10:      return 64'hE28110010000000;
            11:      return 64'hE80000090000000;
            12:      return 64'hE28110640000000;
            default: return '0;
        endcase
    endfunction

    function automatic logic isDataAddr(input addrT a);
        return (a >= addrT'(`MEM_DATA_BASE)) && (a < addrT'(dataEnd));
    endfunction

    function automatic wordT expectedRead(input addrT a);
        if (a < addrT'(`MEM_INSTR_WORDS)) begin
            return programWord(int'(a));
        end else if (isDataAddr(a) && shadow.exists(a)) begin
            return shadow[a];
        end
        return '0;                        // Unmapped reads as zero
    endfunction

    task automatic compareWord(input string what, input addrT addr, input wordT got,
                               input wordT want);
        checkCount++;
        assert (got === want) else begin
            errorCount++;
            $display("error %0t: %s at address %h got %h expected %h",
                     $time, what, addr, got, want);
        end
    endtask

    // One request per falling edge, expectation due two edges later
    task automatic issueRequest(input logic rd, input logic wr, input addrT addr,
                                input wordT data);
        wordT want;
        @(negedge clk);
        read    = rd;
        write   = wr;
        address = addr;
        wdata   = data;
        want    = rd ? expectedRead(addr) : '0;
        if (wr && isDataAddr(addr)) begin
            shadow[addr] = data;
        end
        expWord.push_back(want);
        expAddr.push_back(addr);
        expDue.push_back(cycleCount + 2);
    endtask

    task automatic goIdle();
        @(negedge clk);
        read  = 1'b0;
        write = 1'b0;
    endtask

    task automatic waitDrained();
        while (expWord.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        $display("%s: %0d errors", name, errorCount - errorsBefore);
    endtask

    always @(negedge clk) begin : responseMonitor
        wordT want;
        addrT addr;
        int   due;
        if (arstN) begin
            if (rspValid) begin
                checkCount++;
                assert (expWord.size() > 0) else begin
                    errorCount++;
                    $display("response at %0t came with no request outstanding", $time);
                end
                if (expWord.size() > 0) begin
                    want = expWord.pop_front();
                    addr = expAddr.pop_front();
                    due  = expDue.pop_front();
                    compareWord("rdata", addr, rdata, want);
                    assert (due == cycleCount) else begin
                        errorCount++;
                        $display("response for address %h came at cycle %0d, not %0d",
                                 addr, cycleCount, due);
                    end
                end
            end else if (expDue.size() > 0) begin
                checkCount++;
                assert (expDue[0] > cycleCount) else begin
                    errorCount++;
                    $display("no response for address %h by cycle %0d",
                             expAddr[0], cycleCount);
                    void'(expWord.pop_front());
                    void'(expAddr.pop_front());
                    void'(expDue.pop_front());
                end
            end
        end
    end

    task automatic checkQuiet();
        checkCount++;
        assert (rspValid === 1'b0) else begin
            errorCount++;
            $display("error %0t: rspValid high while idle", $time);
        end
        compareWord("idle rdata", '0, rdata, '0);
    endtask

    task automatic resetQuiet();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (3) begin
            @(negedge clk);
            checkQuiet();
        end
        arstN = 1'b1;                     // Release on a falling edge
        repeat (5) begin
            @(negedge clk);
            checkQuiet();
        end
        reportTest("reset quiet", errorsBefore);
    endtask

    task automatic instrFetch();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int a = 0; a < `MEM_INSTR_WORDS; a++) begin
            issueRequest(1'b1, 1'b0, addrT'(a), '0);
        end
        goIdle();
        waitDrained();
        reportTest("instruction fetch", errorsBefore);
    endtask

    task automatic dataBankAccess();
        int   errorsBefore;
        int   base;
        addrT addrList [$];
        errorsBefore = errorCount;
        for (int b = 0; b < `MEM_BANK_COUNT; b++) begin
            base = `MEM_DATA_BASE + b * `MEM_BANK_WORDS;
            addrList.push_back(addrT'(base));
            addrList.push_back(addrT'(base + `MEM_BANK_WORDS / 2));
            addrList.push_back(addrT'(base + `MEM_BANK_WORDS - 1));
        end
        foreach (addrList[i]) begin
            issueRequest(1'b0, 1'b1, addrList[i], randomWord());
        end
        foreach (addrList[i]) begin
            issueRequest(1'b1, 1'b0, addrList[i], '0);
        end
        goIdle();
        waitDrained();
        reportTest("data banks", errorsBefore);
    endtask

    task automatic romProtection();
        int errorsBefore;
        errorsBefore = errorCount;
        issueRequest(1'b0, 1'b1, addrT'(5), randomWord());
        issueRequest(1'b1, 1'b0, addrT'(5), '0);   // Still the program word
        goIdle();
        waitDrained();
        reportTest("rom protection", errorsBefore);
    endtask

    task automatic unmappedAccess();
        int   errorsBefore;
        addrT lastData;
        addrT highAlias;
        errorsBefore = errorCount;
        lastData  = addrT'(dataEnd - 1);
        highAlias = {1'b1, lastData[`MEM_ADDR_WIDTH-2:0]};   // Word 287 with top bit set
        issueRequest(1'b0, 1'b1, lastData, randomWord());
        issueRequest(1'b1, 1'b0, addrT'(dataEnd), '0);
        issueRequest(1'b1, 1'b0, highAlias, '0);
        issueRequest(1'b0, 1'b1, addrT'(dataEnd), randomWord());
        issueRequest(1'b0, 1'b1, highAlias, randomWord());
        issueRequest(1'b1, 1'b0, lastData, '0);
        goIdle();
        waitDrained();
        reportTest("unmapped addresses", errorsBefore);
    endtask

    task automatic readWriteSame();
        int   errorsBefore;
        addrT addr;
        errorsBefore = errorCount;
        addr = addrT'(`MEM_DATA_BASE + 100);
        issueRequest(1'b0, 1'b1, addr, randomWord());
        issueRequest(1'b1, 1'b1, addr, randomWord());   // Returns the old word
        issueRequest(1'b1, 1'b0, addr, '0);
        goIdle();
        waitDrained();
        reportTest("read and write together", errorsBefore);
    endtask

    initial begin
        arstN    = 1'b0;
        read     = 1'b0;
        write    = 1'b0;
        address  = '0;
        wdata    = '0;
        rngState = 32'h2201;
        resetQuiet();
        instrFetch();
        dataBankAccess();
        romProtection();
        unmappedAccess();
        readWriteSame();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/memPkg.sv
source/memReqIf.sv
source/segmentDecoder.sv
source/bankStorage.sv
source/segmentedMemory.sv
tests/segmentedMemoryTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module segmentedMemoryTb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/VsegmentedMemoryTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
